/* src/videoPkg.sv */
package videoPkg;

	// reduced raster sized for short simulations
	localparam int coordWidth = 7;

	localparam int hActive    = 64;
	localparam int hSyncStart = 68;
	localparam int hSyncEnd   = 76;
	localparam int hTotal     = 80;

	localparam int vActive    = 48;
	localparam int vSyncStart = 50;
	localparam int vSyncEnd   = 52;
	localparam int vTotal     = 56;

	// 8-bit RRRGGGBB colour
	localparam int colourWidth = 8;

	localparam logic [colourWidth-1:0] bgColour     = 8'h00;
	localparam logic [colourWidth-1:0] wallColour   = 8'hff;
	localparam logic [colourWidth-1:0] floorColour  = 8'he0;
	localparam logic [colourWidth-1:0] ballColour   = 8'hfc;
	localparam logic [colourWidth-1:0] paddleColour = 8'h1f;
	localparam logic [colourWidth-1:0] blankColour  = 8'h00;

endpackage

/* src/gamePkg.sv */
package gamePkg;

	// playfield borders
	localparam int wallWidth  = 2;
	localparam int rightWallX = 62;
	localparam int floorY     = 46;

	// ball
	localparam int ballSize   = 4;
	localparam int ballStartX = 30;
	localparam int ballStartY = 10;
	localparam int ballStep   = 1;

	// paddle x is the left edge
	localparam int paddleWidth  = 12;
	localparam int paddleHeight = 2;
	localparam int paddleY      = 40;
	localparam int paddleStartX = 26;
	localparam int paddleStep   = 2;
	localparam int paddleMinX   = 2;
	localparam int paddleMaxX   = 50;

	typedef enum logic {
		PLAY,
		PAUSED
	} gameState_e;

endpackage

/* src/vgaTiming.sv */
`timescale 1ns/1ps

module vgaTiming
	import videoPkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	output logic [coordWidth-1:0] pixelX,
	output logic [coordWidth-1:0] pixelY,
	output logic                  hsyncRaw,
	output logic                  vsyncRaw,
	output logic                  videoOnRaw,
	output logic                  startOfFrame
);

	logic [coordWidth-1:0] hCount;
	logic [coordWidth-1:0] vCount;
	logic                  lineEnd;
	logic                  frameEnd;

	assign lineEnd  = (hCount == coordWidth'(hTotal - 1));
	assign frameEnd = (vCount == coordWidth'(vTotal - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			if (lineEnd) begin
				hCount <= '0;
				if (frameEnd)
					vCount <= '0;
				else
					vCount <= vCount + 1'b1;
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	assign pixelX = hCount;
	assign pixelY = vCount;

	// syncs are active low
	assign hsyncRaw = !((hCount >= coordWidth'(hSyncStart)) &&
		(hCount < coordWidth'(hSyncEnd)));
	assign vsyncRaw = !((vCount >= coordWidth'(vSyncStart)) &&
		(vCount < coordWidth'(vSyncEnd)));

	assign videoOnRaw = (hCount < coordWidth'(hActive)) && (vCount < coordWidth'(vActive));

	// positions update on the last clock of the frame
	assign startOfFrame = lineEnd && frameEnd;

endmodule

/* src/playfield.sv */
`timescale 1ns/1ps

module playfield
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic [coordWidth-1:0]  pixelX,
	input  logic [coordWidth-1:0]  pixelY,
	output logic [colourWidth-1:0] bgRgb,
	output logic                   drawSideWall,
	output logic                   drawTopWall,
	output logic                   drawFloor
);

	assign drawSideWall = (pixelX < coordWidth'(wallWidth)) ||
		(pixelX >= coordWidth'(rightWallX));
	assign drawTopWall  = (pixelY < coordWidth'(wallWidth));
	assign drawFloor    = (pixelY >= coordWidth'(floorY));

	// floor wins in the bottom corners
	always_comb begin
		if (drawFloor)
			bgRgb = floorColour;
		else if (drawSideWall || drawTopWall)
			bgRgb = wallColour;
		else
			bgRgb = bgColour;
	end

endmodule

/* src/ballObject.sv */
`timescale 1ns/1ps

module ballObject
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [coordWidth-1:0] pixelX,
	input  logic [coordWidth-1:0] pixelY,
	input  logic                  startOfFrame,
	input  logic                  hitSide,
	input  logic                  hitTop,
	input  logic                  hitPaddle,
	input  logic                  relaunch,
	input  logic                  paused,
	output logic                  drawBall
);

	logic [coordWidth-1:0] ballX;
	logic [coordWidth-1:0] ballY;
	logic                  dirRight;
	logic                  dirDown;

	logic                  nextDirRight;
	logic                  nextDirDown;
	logic [coordWidth-1:0] nextX;
	logic [coordWidth-1:0] nextY;

	// bounce first, then step along the new direction
	always_comb begin
		nextDirRight = hitSide ? !dirRight : dirRight;

		nextDirDown = dirDown;
		if (hitTop)
			nextDirDown = 1'b1;
		if (hitPaddle)
			nextDirDown = 1'b0;

		if (nextDirRight)
			nextX = coordWidth'(ballX + ballStep);
		else
			nextX = coordWidth'(ballX - ballStep);

		if (nextDirDown)
			nextY = coordWidth'(ballY + ballStep);
		else
			nextY = coordWidth'(ballY - ballStep);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ballX    <= coordWidth'(ballStartX);
			ballY    <= coordWidth'(ballStartY);
			dirRight <= 1'b1;
			dirDown  <= 1'b1;
		end else if (startOfFrame) begin
			if (relaunch) begin
				ballX    <= coordWidth'(ballStartX);
				ballY    <= coordWidth'(ballStartY);
				dirRight <= 1'b1;
				dirDown  <= 1'b1;
			end else if (!paused) begin
				ballX    <= nextX;
				ballY    <= nextY;
				dirRight <= nextDirRight;
				dirDown  <= nextDirDown;
			end
		end
	end

	// square of ballSize from the top-left corner
	assign drawBall = (pixelX >= ballX) &&
		(pixelX < coordWidth'(ballX + ballSize)) &&
		(pixelY >= ballY) &&
		(pixelY < coordWidth'(ballY + ballSize));

endmodule

/* src/paddleObject.sv */
`timescale 1ns/1ps

module paddleObject
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [coordWidth-1:0] pixelX,
	input  logic [coordWidth-1:0] pixelY,
	input  logic                  startOfFrame,
	input  logic                  leftKey,
	input  logic                  rightKey,
	input  logic                  paused,
	output logic                  drawPaddle
);

	logic [coordWidth-1:0] paddleX;

	always_ff @(posedge clk) begin
		if (rst) begin
			paddleX <= coordWidth'(paddleStartX);
		end else if (startOfFrame && !paused && (leftKey != rightKey)) begin
			if (rightKey) begin
				if (paddleX >= coordWidth'(paddleMaxX - paddleStep))
					paddleX <= coordWidth'(paddleMaxX);
				else
					paddleX <= coordWidth'(paddleX + paddleStep);
			end else begin
				if (paddleX <= coordWidth'(paddleMinX + paddleStep))
					paddleX <= coordWidth'(paddleMinX);
				else
					paddleX <= coordWidth'(paddleX - paddleStep);
			end
		end
	end

	// the row is fixed and only x moves
	assign drawPaddle = (pixelX >= paddleX) &&
		(pixelX < coordWidth'(paddleX + paddleWidth)) &&
		(pixelY >= coordWidth'(paddleY)) &&
		(pixelY < coordWidth'(paddleY + paddleHeight));

endmodule

/* src/collisionMonitor.sv */
`timescale 1ns/1ps

module collisionMonitor
	import gamePkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic startOfFrame,
	input  logic drawBall,
	input  logic drawSideWall,
	input  logic drawTopWall,
	input  logic drawFloor,
	input  logic drawPaddle,
	input  logic serveKey,
	output logic hitSide,
	output logic hitTop,
	output logic hitPaddle,
	output logic relaunch,
	output logic paused
);

	gameState_e state;
	logic       hitFloor;

	// sticky per frame and cleared at the frame boundary
	always_ff @(posedge clk) begin
		if (rst || startOfFrame) begin
			hitSide   <= 1'b0;
			hitTop    <= 1'b0;
			hitPaddle <= 1'b0;
			hitFloor  <= 1'b0;
		end else begin
			hitSide   <= hitSide   || (drawBall && drawSideWall);
			hitTop    <= hitTop    || (drawBall && drawTopWall);
			hitPaddle <= hitPaddle || (drawBall && drawPaddle);
			hitFloor  <= hitFloor  || (drawBall && drawFloor);
		end
	end

	assign relaunch = startOfFrame && (state == PAUSED) && serveKey;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= PLAY;
		end else if (startOfFrame) begin
			case (state)
				PLAY:    if (hitFloor) state <= PAUSED;
				PAUSED:  if (serveKey) state <= PLAY;
				default: state <= PLAY;
			endcase
		end
	end

	assign paused = (state == PAUSED);

endmodule

/* src/pixelMixer.sv */
`timescale 1ns/1ps

module pixelMixer
	import videoPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   drawBall,
	input  logic                   drawPaddle,
	input  logic [colourWidth-1:0] bgRgb,
	input  logic                   videoOnRaw,
	input  logic                   hsyncRaw,
	input  logic                   vsyncRaw,
	output logic [colourWidth-1:0] rgb,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   videoOn
);

	logic [colourWidth-1:0] rgbNext;

	// ball over paddle over background
	always_comb begin
		if (!videoOnRaw)
			rgbNext = blankColour;
		else if (drawBall)
			rgbNext = ballColour;
		else if (drawPaddle)
			rgbNext = paddleColour;
		else
			rgbNext = bgRgb;
	end

	always_ff @(posedge clk) begin
		rgb <= rgbNext;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			videoOn <= 1'b0;
		end else begin
			hsync   <= hsyncRaw;
			vsync   <= vsyncRaw;
			videoOn <= videoOnRaw;
		end
	end

endmodule

/* src/pongTop.sv */
`timescale 1ns/1ps

module pongTop
	import videoPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   leftKey,
	input  logic                   rightKey,
	input  logic                   serveKey,
	output logic [colourWidth-1:0] rgb,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   videoOn,
	output logic                   paused
);

	logic [coordWidth-1:0]  pixelX;
	logic [coordWidth-1:0]  pixelY;
	logic                   hsyncRaw;
	logic                   vsyncRaw;
	logic                   videoOnRaw;
	logic                   startOfFrame;

	logic [colourWidth-1:0] bgRgb;
	logic                   drawSideWall;
	logic                   drawTopWall;
	logic                   drawFloor;
	logic                   drawBall;
	logic                   drawPaddle;

	logic                   hitSide;
	logic                   hitTop;
	logic                   hitPaddle;
	logic                   relaunch;

	vgaTiming vgaTimingInst (
		.clk(clk),
		.rst(rst),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.hsyncRaw(hsyncRaw),
		.vsyncRaw(vsyncRaw),
		.videoOnRaw(videoOnRaw),
		.startOfFrame(startOfFrame)
	);

	playfield playfieldInst (
		.pixelX(pixelX),
		.pixelY(pixelY),
		.bgRgb(bgRgb),
		.drawSideWall(drawSideWall),
		.drawTopWall(drawTopWall),
		.drawFloor(drawFloor)
	);

	ballObject ballObjectInst (
		.clk(clk),
		.rst(rst),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.startOfFrame(startOfFrame),
		.hitSide(hitSide),
		.hitTop(hitTop),
		.hitPaddle(hitPaddle),
		.relaunch(relaunch),
		.paused(paused),
		.drawBall(drawBall)
	);

	paddleObject paddleObjectInst (
		.clk(clk),
		.rst(rst),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.startOfFrame(startOfFrame),
		.leftKey(leftKey),
		.rightKey(rightKey),
		.paused(paused),
		.drawPaddle(drawPaddle)
	);

	collisionMonitor collisionMonitorInst (
		.clk(clk),
		.rst(rst),
		.startOfFrame(startOfFrame),
		.drawBall(drawBall),
		.drawSideWall(drawSideWall),
		.drawTopWall(drawTopWall),
		.drawFloor(drawFloor),
		.drawPaddle(drawPaddle),
		.serveKey(serveKey),
		.hitSide(hitSide),
		.hitTop(hitTop),
		.hitPaddle(hitPaddle),
		.relaunch(relaunch),
		.paused(paused)
	);

	pixelMixer pixelMixerInst (
		.clk(clk),
		.rst(rst),
		.drawBall(drawBall),
		.drawPaddle(drawPaddle),
		.bgRgb(bgRgb),
		.videoOnRaw(videoOnRaw),
		.hsyncRaw(hsyncRaw),
		.vsyncRaw(vsyncRaw),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync),
		.videoOn(videoOn)
	);

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
	output logic clk
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = !clk;
	end

endmodule

/* dv/pongTop_sva.sv */
`timescale 1ns/1ps

module pongTopSva
	import gamePkg::*;
(
	input logic clk,
	input logic rst,
	input logic startOfFrame,
	input logic relaunch,
	input logic paused,
	input logic hsync,
	input logic vsync
);

	gameState_e state;
	int         failures = 0;

	assign state = paused ? PAUSED : PLAY;

	startPulse: assert property (@(posedge clk) disable iff (rst) startOfFrame |=> !startOfFrame)
		else begin
			failures++;
			$error("startOfFrame held high for more than one cycle");
		end

	// a serve leaves the paused state on the next clock
	relaunchPaused: assert property (@(posedge clk) disable iff (rst)
		relaunch |-> (state == PAUSED) ##1 (state == PLAY))
		else begin
			failures++;
			$error("relaunch outside the paused state or without a return to play");
		end

	// state only moves at the frame boundary
	pausedStable: assert property (@(posedge clk) disable iff (rst)
		(paused != $past(paused)) |-> $past(startOfFrame))
		else begin
			failures++;
			$error("paused changed away from a frame boundary");
		end

	syncIdle: assert property (@(posedge clk) rst |=> hsync && vsync)
		else begin
			failures++;
			$error("sync outputs not idle during reset");
		end

endmodule

bind pongTop pongTopSva svaInst (
	.clk(clk),
	.rst(rst),
	.startOfFrame(startOfFrame),
	.relaunch(relaunch),
	.paused(paused),
	.hsync(hsync),
	.vsync(vsync)
);

/* dv/pongTb.sv */
`timescale 1ns/1ps

module pongTb
	import videoPkg::*;
	import gamePkg::*;
();

	logic                   clk;
	logic                   rst;
	logic                   leftKey;
	logic                   rightKey;
	logic                   serveKey;
	logic [colourWidth-1:0] rgb;
	logic                   hsync;
	logic                   vsync;
	logic                   videoOn;
	logic                   paused;

	int errors;
	int px, py;
	int cycleNo, lastVsyncFall, vsyncGap;
	logic prevVsync;
	int hsyncLowCount, videoOnCount;
	logic [colourWidth-1:0] frameRgb [0:hActive*vActive-1];
	int ballMinX, ballMinY, ballMaxX, ballMaxY;
	int padMinX, padMinY, padMaxX, padMaxY;
	// reference model of ball, paddle and game state
	int mBallX, mBallY, mPadX;
	bit mRight, mDown, mPaused;
	bit sawSideHit, sawWallCover, lastHitPaddle;

	tbClock clockGen (.clk(clk));

	pongTop uut (
		.clk(clk),
		.rst(rst),
		.leftKey(leftKey),
		.rightKey(rightKey),
		.serveKey(serveKey),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync),
		.videoOn(videoOn),
		.paused(paused)
	);

	task logFailure(input string msg);
		errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task reportProblem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// px and py track the pixel now at the outputs
	task stepCycle();
		@(posedge clk);
		#1;
		cycleNo++;
		if (px == hTotal - 1) begin
			px = 0;
			py = (py == vTotal - 1) ? 0 : py + 1;
		end else begin
			px++;
		end
		if (prevVsync && !vsync) begin
			if (lastVsyncFall >= 0)
				vsyncGap = cycleNo - lastVsyncFall;
			lastVsyncFall = cycleNo;
		end
		prevVsync = vsync;
	endtask

	task captureFrame();
		ballMinX = 999;
		ballMinY = 999;
		ballMaxX = -1;
		ballMaxY = -1;
		padMinX = 999;
		padMinY = 999;
		padMaxX = -1;
		padMaxY = -1;
		hsyncLowCount = 0;
		videoOnCount = 0;
		repeat (4480) begin
			stepCycle();
			if (hsync !== !(px >= 68 && px < 76))
				logFailure($sformatf("hsync wrong at (%0d,%0d)", px, py));
			if (vsync !== !(py >= 50 && py < 52))
				logFailure($sformatf("vsync wrong at (%0d,%0d)", px, py));
			if (videoOn !== (px < 64 && py < 48))
				logFailure($sformatf("videoOn wrong at (%0d,%0d)", px, py));
			if (!hsync)
				hsyncLowCount++;
			if (videoOn)
				videoOnCount++;
			if (px < hActive && py < vActive) begin
				frameRgb[py*hActive+px] = rgb;
				if (rgb == ballColour) begin
					ballMinX = (px < ballMinX) ? px : ballMinX;
					ballMaxX = (px > ballMaxX) ? px : ballMaxX;
					ballMinY = (py < ballMinY) ? py : ballMinY;
					ballMaxY = (py > ballMaxY) ? py : ballMaxY;
				end
				if (rgb == paddleColour) begin
					padMinX = (px < padMinX) ? px : padMinX;
					padMaxX = (px > padMaxX) ? px : padMaxX;
					padMinY = (py < padMinY) ? py : padMinY;
					padMaxY = (py > padMaxY) ? py : padMaxY;
				end
			end else if (rgb !== blankColour) begin
				logFailure($sformatf("rgb %h outside the active region at (%0d,%0d)",
					rgb, px, py));
			end
		end
	endtask

	// capture one frame, compare with the model, then step the model
	task runFrame();
		bit hitS, hitT, hitP, hitF;
		int col;
		captureFrame();
		hitS = (ballMinX < 2) || (ballMaxX >= 62);
		hitT = (ballMinY < 2);
		hitF = (ballMaxY >= 46);
		hitP = (ballMaxX >= mPadX) && (ballMinX < mPadX + 12) &&
			(ballMaxY >= 40) && (ballMinY < 42);
		lastHitPaddle = hitP;
		if (ballMinX != mBallX || ballMinY != mBallY || ballMaxX != mBallX + 3 ||
			ballMaxY != mBallY + 3)
			logFailure($sformatf("ball box (%0d,%0d)-(%0d,%0d), expected corner (%0d,%0d)",
				ballMinX, ballMinY, ballMaxX, ballMaxY, mBallX, mBallY));
		if (!hitP) begin
			if (padMinX != mPadX || padMaxX != mPadX + 11 || padMinY != 40 || padMaxY != 41)
				logFailure($sformatf("paddle box (%0d,%0d)-(%0d,%0d), expected x %0d",
					padMinX, padMinY, padMaxX, padMaxY, mPadX));
		end else if (padMinX < mPadX || padMaxX > mPadX + 11) begin
			logFailure($sformatf("paddle box x %0d-%0d outside %0d", padMinX, padMaxX, mPadX));
		end
		if (hitS) begin
			sawSideHit = 1;
			// wall column under the model's ball edge
			col = (mBallX < 2) ? mBallX : mBallX + 3;
			if ((col < 2 || (col >= 62 && col < hActive)) &&
				frameRgb[mBallY*hActive+col] == ballColour)
				sawWallCover = 1;
		end
		if (mPaused) begin
			if (serveKey) begin
				mBallX = 30;
				mBallY = 10;
				mRight = 1;
				mDown = 1;
				mPaused = 0;
			end
		end else begin
			if (hitS)
				mRight = !mRight;
			if (hitT)
				mDown = 1;
			if (hitP)
				mDown = 0;
			mBallX = mRight ? mBallX + 1 : mBallX - 1;
			mBallY = mDown ? mBallY + 1 : mBallY - 1;
			if (rightKey && !leftKey)
				mPadX = (mPadX + 2 > 50) ? 50 : mPadX + 2;
			else if (leftKey && !rightKey)
				mPadX = (mPadX - 2 < 2) ? 2 : mPadX - 2;
			if (hitF)
				mPaused = 1;
		end
		if (paused !== mPaused)
			logFailure($sformatf("paused is %b, expected %b", paused, mPaused));
	endtask

	task resetImageTest();
		runFrame();
		if (ballMinX != 30 || ballMinY != 10 || ballMaxX != 33 || ballMaxY != 13)
			logFailure("first frame ball not a 4x4 box at (30,10)");
		if (padMinX != 26 || padMinY != 40 || padMaxX != 37 || padMaxY != 41)
			logFailure("first frame paddle not a 12x2 box at (26,40)");
		if (frameRgb[5*hActive] != 8'hff || frameRgb[20*hActive+63] != 8'hff)
			logFailure("side wall pixels not wall colour");
		if (frameRgb[20] != 8'hff)
			logFailure("top wall pixel not wall colour");
		if (frameRgb[47*hActive+20] != 8'he0)
			logFailure("floor pixel not floor colour");
		if (frameRgb[20*hActive+20] != 8'h00)
			logFailure("open field pixel not background colour");
	endtask

	task rasterTest();
		runFrame();
		runFrame();
		if (vsyncGap != 4480)
			logFailure($sformatf("vsync period %0d cycles", vsyncGap));
		if (hsyncLowCount != 448)
			logFailure($sformatf("hsync low for %0d cycles per frame", hsyncLowCount));
		if (videoOnCount != 3072)
			logFailure($sformatf("videoOn high for %0d cycles per frame", videoOnCount));
	endtask

	task motionTest();
		sawSideHit = 0;
		sawWallCover = 0;
		repeat (30) runFrame();
		if (!sawSideHit)
			reportProblem("the ball never reached a side wall in the motion test");
		if (!sawWallCover)
			reportProblem("no ball pixel was seen over a side wall");
	endtask

	task missServeTest();
		int frames;
		frames = 0;
		while (!mPaused && frames < 100) begin
			runFrame();
			frames++;
		end
		if (!mPaused)
			reportProblem("timeout: the ball never reached the floor");
		// keys must be ignored while paused
		rightKey = 1;
		repeat (3) runFrame();
		rightKey = 0;
		serveKey = 1;
		runFrame();
		serveKey = 0;
		if (paused !== 1'b0)
			logFailure("paused still high after serve");
		runFrame();
		if (ballMinX != 30 || ballMinY != 10)
			logFailure($sformatf("served ball at (%0d,%0d)", ballMinX, ballMinY));
	endtask

	task paddleTest();
		rightKey = 1;
		repeat (15) runFrame();
		rightKey = 0;
		runFrame();
		if (padMinX != 50)
			logFailure($sformatf("paddle at %0d after right clamp", padMinX));
		leftKey = 1;
		repeat (5) runFrame();
		rightKey = 1;
		repeat (3) runFrame();
		leftKey = 0;
		rightKey = 0;
		if (padMinX != 40)
			logFailure($sformatf("paddle at %0d with both keys held", padMinX));
	endtask

	task reboundTest();
		int frames;
		int target;
		int prevY;
		frames = 0;
		lastHitPaddle = 0;
		while (!lastHitPaddle && frames < 200) begin
			target = mBallX - 4;
			rightKey = (mPadX < target - 1);
			leftKey = (mPadX > target + 1);
			serveKey = mPaused;
			runFrame();
			frames++;
		end
		leftKey = 0;
		rightKey = 0;
		serveKey = 0;
		if (!lastHitPaddle) begin
			reportProblem("timeout: the paddle never met the ball");
		end else begin
			prevY = ballMinY;
			runFrame();
			if (ballMinY >= prevY)
				logFailure($sformatf("ball y %0d after paddle hit at y %0d", ballMinY, prevY));
			if (paused !== 1'b0)
				logFailure("paused high after a paddle rebound");
		end
	endtask

	initial begin
		errors = 0;
		rst = 1;
		leftKey = 0;
		rightKey = 0;
		serveKey = 0;
		px = hTotal - 1;
		py = vTotal - 1;
		cycleNo = 0;
		lastVsyncFall = -1;
		vsyncGap = 0;
		prevVsync = 1;
		mBallX = 30;
		mBallY = 10;
		mPadX = 26;
		mRight = 1;
		mDown = 1;
		mPaused = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 0;
		resetImageTest();
		rasterTest();
		motionTest();
		missServeTest();
		paddleTest();
		reboundTest();
		$display("errors: %0d, assertion failures: %0d", errors, uut.svaInst.failures);
		if (errors == 0 && uut.svaInst.failures == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* files.f */
src/videoPkg.sv
src/gamePkg.sv
src/vgaTiming.sv
src/playfield.sv
src/ballObject.sv
src/paddleObject.sv
src/collisionMonitor.sv
src/pixelMixer.sv
src/pongTop.sv
dv/tbClock.sv
dv/pongTop_sva.sv
dv/pongTb.sv

/* Bender.yml */
package:
  name: pong

sources:
  - src/videoPkg.sv
  - src/gamePkg.sv
  - src/vgaTiming.sv
  - src/playfield.sv
  - src/ballObject.sv
  - src/paddleObject.sv
  - src/collisionMonitor.sv
  - src/pixelMixer.sv
  - src/pongTop.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/pongTop_sva.sv
      - dv/pongTb.sv
